//--- flist.f
source/n64_ppu_pkg.sv
source/n64_vdemux.sv
source/n64_vinfo.sv
source/scanline_emu.sv
source/n64_ppu_top.sv
sim/tb_clk_gen.sv
sim/tb_n64_ppu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass only on the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_n64_ppu -f flist.f || { echo "build failed"; exit 1; }

out="$(./obj_dir/Vtb_n64_ppu)"
echo "$out"
echo "$out" | grep -qx "Everything OK" && exit 0 || exit 1

//--- sim/tb_clk_gen.sv
// Testbench clock and reset

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset held low for a fixed number of rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- sim/tb_n64_ppu.sv
// N64 PPU input stage testbench

`timescale 1ns/1ps

module tb_n64_ppu;

  import n64_ppu_pkg::*;

  localparam int PIX_PER_LINE  = 3;
  localparam int CLK_PERIOD_NS = 8;
  localparam int SMALL_LINES   = 6;
  localparam int PAL_LINES     = 313;
  localparam int NTSC_LINES    = 262;
  // six short frames, three PAL frames, five NTSC frames (one of them a line longer)
  localparam int TOTAL_LINES   = 6 * SMALL_LINES + 3 * PAL_LINES + 5 * NTSC_LINES + 1;
  localparam longint WATCHDOG_NS =
    longint'(TOTAL_LINES) * PIX_PER_LINE * 4 * CLK_PERIOD_NS * 2;

  logic     clk;
  logic     arst_n;
  logic     nvdsync;
  color_t   vd;
  ppu_cfg_t cfg;
  vinfo_t   vinfo;
  logic     pix_valid;
  pixel_t   pix;

  pixel_t      exp_q[$];
  logic [31:0] lfsr = 32'hefa0;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_err_start = 0;
  // lengths of the current frame and the two frames before it
  int          cur_len = 0;
  int          newer_len = 0;
  int          older_len = 0;

  tb_clk_gen #(
    .PERIOD_NS (CLK_PERIOD_NS),
    .RST_CYCLES(4)
  ) u_clk_gen (
    .clk_o  (clk),
    .rst_n_o(arst_n)
  );

  n64_ppu_top #(
    .COLOR_W   (COLOR_W),
    .LINE_CNT_W(LINE_CNT_W)
  ) u_n64_ppu_top (
    .N64_CLK_i  (clk),
    .arst_n_i   (arst_n),
    .nVDSYNC_i  (nvdsync),
    .VD_i       (vd),
    .cfg_i      (cfg),
    .vinfo_o    (vinfo),
    .pix_valid_o(pix_valid),
    .pix_o      (pix)
  );

  // ====================
  // reference model
  // ====================

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // 16-bit reduction first, then darkening on odd lines
  function automatic color_t ref_channel(input color_t v, input ppu_cfg_t c, input bit odd);
    int x;
    x = int'(v);
    if (c.n16bit_mode) begin
      x = x - (x % 4);
    end
    if (c.sl_en && odd) begin
      x = x - (x * int'(c.sl_str)) / 16;
    end
    return color_t'(x);
  endfunction

  function automatic pixel_t ref_pixel(input pixel_t sent, input ppu_cfg_t c, input int line);
    pixel_t p;
    p = sent;
    p.rgb.r = ref_channel(sent.rgb.r, c, line % 2 == 1);
    p.rgb.g = ref_channel(sent.rgb.g, c, line % 2 == 1);
    p.rgb.b = ref_channel(sent.rgb.b, c, line % 2 == 1);
    return p;
  endfunction

  // mode flags from the last complete frame and the one before it
  function automatic vinfo_t expected_vinfo(input int last, input int prev);
    vinfo_t v;
    v.vdata_detected = 1'b1;
    v.palmode        = last >= PAL_LINES_MIN;
    v.n64_480i       = last != prev;
    return v;
  endfunction

  // ====================
  // stimulus tasks
  // ====================

  task automatic send_word(input logic nsync, input color_t w);
    @(posedge clk);
    nvdsync <= nsync;
    vd      <= w;
  endtask

  task automatic send_pixel(input bit vs, input bit hs, input int line);
    logic [31:0] rnd;
    pixel_t      sent;
    color_t      sw;
    take_bits(3 * COLOR_W + 1, rnd);
    sent.sync.vsync = vs;
    sent.sync.hsync = hs;
    // composite sync drawn at random
    sent.sync.csync = rnd[3*COLOR_W];
    sent.rgb        = rgb_t'(rnd[3*COLOR_W-1:0]);
    // bus flags are active low
    sw    = '0;
    sw[3] = !vs;
    sw[1] = !hs;
    sw[0] = !sent.sync.csync;
    exp_q.push_back(ref_pixel(sent, cfg, line));
    send_word(1'b0, sw);
    send_word(1'b1, sent.rgb.r);
    send_word(1'b1, sent.rgb.g);
    send_word(1'b1, sent.rgb.b);
  endtask

  task automatic send_frame(input int lines);
    older_len = newer_len;
    newer_len = cur_len;
    cur_len   = lines;
    for (int l = 0; l < lines; l++) begin
      for (int p = 0; p < PIX_PER_LINE; p++) begin
        send_pixel(l == 0 && p == 0, p == 0, l);
      end
    end
  endtask

  // idle the bus until every sent pixel came out
  task automatic drain();
    @(posedge clk);
    nvdsync <= 1'b1;
    vd      <= '0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic set_cfg(input ppu_cfg_t c);
    drain();
    @(posedge clk);
    cfg <= c;
    @(posedge clk);
  endtask

  task automatic check_vinfo(input vinfo_t e);
    checks++;
    assert (vinfo == e) else begin
      $display("** Error: vinfo_o = %h, expected %h", vinfo, e);
      errors++;
    end
  endtask

  task automatic begin_test();
    test_err_start = errors;
  endtask

  task automatic end_test(input string name);
    drain();
    tests_run++;
    if (errors != test_err_start) begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, errors - test_err_start);
    end else begin
      $display("test %s: passed", name);
    end
  endtask

  // ====================
  // compare and watchdog
  // ====================

  always @(negedge clk) begin
    pixel_t e;
    if (arst_n && pix_valid) begin
      checks++;
      assert (exp_q.size() != 0) else begin
        $display("pix_valid_o went high although no pixel was sent for it");
        errors++;
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        assert (pix == e) else begin
          $display("** Error: pix_o = %h, expected %h", pix, e);
          errors++;
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, stimulus did not finish within %0d ns", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

  // ====================
  // test sequence
  // ====================

  initial begin
    ppu_cfg_t    c;
    logic [31:0] rnd;
    nvdsync = 1'b1;
    vd      = '0;
    cfg     = '0;
    @(posedge arst_n);
    @(negedge clk);

    begin_test();
    checks++;
    assert (!pix_valid && pix == '0) else begin
      $display("** Error: pix_valid_o = %h, pix_o = %h, expected 0 and 0", pix_valid, pix);
      errors++;
    end
    check_vinfo('0);
    end_test("reset state");

    begin_test();
    set_cfg('0);
    repeat (2) send_frame(SMALL_LINES);
    end_test("pass-through");

    // strength set while scanlines stay off
    begin_test();
    c             = '0;
    c.n16bit_mode = 1'b1;
    c.sl_str      = 4'hf;
    set_cfg(c);
    repeat (2) send_frame(SMALL_LINES);
    end_test("16-bit mode");

    // a fresh random strength for each frame
    begin_test();
    repeat (2) begin
      take_bits(4, rnd);
      c        = '0;
      c.sl_en  = 1'b1;
      c.sl_str = rnd[3:0];
      set_cfg(c);
      send_frame(SMALL_LINES);
    end
    end_test("scanlines");

    begin_test();
    set_cfg('0);
    repeat (3) send_frame(PAL_LINES);
    drain();
    check_vinfo(expected_vinfo(newer_len, older_len));
    end_test("PAL detection");

    begin_test();
    send_frame(NTSC_LINES);
    send_frame(NTSC_LINES + 1);
    send_frame(NTSC_LINES);
    drain();
    check_vinfo(expected_vinfo(newer_len, older_len));
    send_frame(NTSC_LINES);
    send_frame(NTSC_LINES);
    drain();
    check_vinfo(expected_vinfo(newer_len, older_len));
    end_test("480i detection");

    $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- source/n64_ppu_pkg.sv
// N64 video input shared types

package n64_ppu_pkg;

  // ====================
  // widths
  // ====================

  // one channel on the N64 video bus
  parameter int COLOR_W = 7;

  // lines per frame fit easily in 10 bits
  parameter int LINE_CNT_W = 10;

  // frames with at least this many lines are PAL
  parameter int PAL_LINES_MIN = 290;

  typedef logic [COLOR_W-1:0]    color_t;
  typedef logic [LINE_CNT_W-1:0] line_cnt_t;
  typedef logic [3:0]            sl_str_t;

  // ====================
  // bundles
  // ====================

  typedef struct packed {
    color_t r;
    color_t g;
    color_t b;
  } rgb_t;

  // active high, inverted from the bus
  typedef struct packed {
    logic vsync;
    logic hsync;
    logic csync;
  } sync_t;

  typedef struct packed {
    sync_t sync;
    rgb_t  rgb;
  } pixel_t;

  typedef struct packed {
    logic vdata_detected;
    logic palmode;
    logic n64_480i;
  } vinfo_t;

  typedef struct packed {
    logic    n16bit_mode;
    logic    sl_en;
    sl_str_t sl_str;
  } ppu_cfg_t;

  // word position within one pixel on the bus
  typedef enum logic [1:0] {
    ST_SYNC  = 2'd0,
    ST_RED   = 2'd1,
    ST_GREEN = 2'd2,
    ST_BLUE  = 2'd3
  } demux_state_t;

endpackage

//--- source/n64_ppu_top.sv
// N64 video processing input stage

`timescale 1ns/1ps

module n64_ppu_top #(
  parameter int COLOR_W    = n64_ppu_pkg::COLOR_W,
  parameter int LINE_CNT_W = n64_ppu_pkg::LINE_CNT_W
) (
  input  logic                  N64_CLK_i,
  input  logic                  arst_n_i,
  input  logic                  nVDSYNC_i,
  input  logic [COLOR_W-1:0]    VD_i,
  input  n64_ppu_pkg::ppu_cfg_t cfg_i,
  output n64_ppu_pkg::vinfo_t   vinfo_o,
  output logic                  pix_valid_o,
  output n64_ppu_pkg::pixel_t   pix_o
);

  import n64_ppu_pkg::*;

  logic   demux_valid;
  pixel_t demux_pix;

  // ====================
  // bus demux
  // ====================

  n64_vdemux #(
    .COLOR_W(COLOR_W)
  ) u_vdemux (
    .N64_CLK_i    (N64_CLK_i),
    .arst_n_i     (arst_n_i),
    .nVDSYNC_i    (nVDSYNC_i),
    .vd_i         (VD_i),
    .n16bit_mode_i(cfg_i.n16bit_mode),
    .pix_valid_o  (demux_valid),
    .pix_o        (demux_pix)
  );

  // side detector, taps the demuxed stream
  n64_vinfo #(
    .LINE_CNT_W(LINE_CNT_W)
  ) u_vinfo (
    .N64_CLK_i  (N64_CLK_i),
    .arst_n_i   (arst_n_i),
    .pix_valid_i(demux_valid),
    .pix_i      (demux_pix),
    .vinfo_o    (vinfo_o)
  );

  // ====================
  // post processing
  // ====================

  scanline_emu #(
    .COLOR_W(COLOR_W)
  ) u_scanline_emu (
    .N64_CLK_i  (N64_CLK_i),
    .arst_n_i   (arst_n_i),
    .pix_valid_i(demux_valid),
    .pix_i      (demux_pix),
    .sl_en_i    (cfg_i.sl_en),
    .sl_str_i   (cfg_i.sl_str),
    .pix_valid_o(pix_valid_o),
    .pix_o      (pix_o)
  );

endmodule

//--- source/n64_vdemux.sv
// N64 video bus demultiplexer

`timescale 1ns/1ps

module n64_vdemux #(
  parameter int COLOR_W = n64_ppu_pkg::COLOR_W
) (
  input  logic                 N64_CLK_i,
  input  logic                 arst_n_i,
  input  logic                 nVDSYNC_i,
  input  logic [COLOR_W-1:0]   vd_i,
  input  logic                 n16bit_mode_i,
  output logic                 pix_valid_o,
  output n64_ppu_pkg::pixel_t  pix_o
);

  import n64_ppu_pkg::*;

  demux_state_t       state;
  sync_t              sync_q;
  logic [COLOR_W-1:0] red_q;
  logic [COLOR_W-1:0] green_q;

  // drop the two low bits in 16-bit color mode
  function automatic logic [COLOR_W-1:0] reduce(input logic [COLOR_W-1:0] c,
                                                input logic               en);
    logic [COLOR_W-1:0] mask;
    mask = {{(COLOR_W-2){1'b1}}, 2'b00};
    return en ? (c & mask) : c;
  endfunction

  // ====================
  // word sequencer
  // ====================

  // a sync word always restarts the sequence
  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state <= ST_SYNC;
    end else if (!nVDSYNC_i) begin
      state <= ST_RED;
    end else begin
      case (state)
        ST_RED:   state <= ST_GREEN;
        ST_GREEN: state <= ST_BLUE;
        ST_BLUE:  state <= ST_SYNC;
        default:  state <= ST_SYNC;
      endcase
    end
  end

  // bus flags are active low
  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= '0;
    end else if (!nVDSYNC_i) begin
      sync_q.vsync <= ~vd_i[3];
      sync_q.hsync <= ~vd_i[1];
      sync_q.csync <= ~vd_i[0];
    end
  end

  // color words
  always_ff @(posedge N64_CLK_i) begin
    if (nVDSYNC_i && state == ST_RED) begin
      red_q <= vd_i;
    end
    if (nVDSYNC_i && state == ST_GREEN) begin
      green_q <= vd_i;
    end
  end

  // ====================
  // pixel output
  // ====================

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pix_valid_o <= 1'b0;
    end else begin
      pix_valid_o <= nVDSYNC_i && (state == ST_BLUE);
    end
  end

  // blue goes straight from the bus into the pixel
  always_ff @(posedge N64_CLK_i) begin
    if (nVDSYNC_i && state == ST_BLUE) begin
      pix_o.sync  <= sync_q;
      pix_o.rgb.r <= reduce(red_q, n16bit_mode_i);
      pix_o.rgb.g <= reduce(green_q, n16bit_mode_i);
      pix_o.rgb.b <= reduce(vd_i, n16bit_mode_i);
    end
  end

  // at least four words per pixel, so never back to back
  a_valid_single: assert property (@(posedge N64_CLK_i) disable iff (!arst_n_i)
    pix_valid_o |=> !pix_valid_o);

endmodule

//--- source/n64_vinfo.sv
// N64 video mode detection

`timescale 1ns/1ps

module n64_vinfo #(
  parameter int LINE_CNT_W = n64_ppu_pkg::LINE_CNT_W
) (
  input  logic                N64_CLK_i,
  input  logic                arst_n_i,
  input  logic                pix_valid_i,
  input  n64_ppu_pkg::pixel_t pix_i,
  output n64_ppu_pkg::vinfo_t vinfo_o
);

  import n64_ppu_pkg::*;

  logic                  vsync_q;
  logic                  hsync_q;
  logic                  vs_rise;
  logic                  hs_rise;
  logic [LINE_CNT_W-1:0] line_cnt;
  logic [LINE_CNT_W-1:0] line_cnt_prev;
  // frame ends seen so far, saturating at two
  logic [1:0]            frame_ends;

  assign vs_rise = pix_valid_i && pix_i.sync.vsync && !vsync_q;
  assign hs_rise = pix_valid_i && pix_i.sync.hsync && !hsync_q;

  // ====================
  // edge tracking
  // ====================

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vsync_q <= 1'b0;
      hsync_q <= 1'b0;
    end else if (pix_valid_i) begin
      vsync_q <= pix_i.sync.vsync;
      hsync_q <= pix_i.sync.hsync;
    end
  end

  // ====================
  // line counting
  // ====================

  // first line of a frame counts as line one
  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      line_cnt      <= '0;
      line_cnt_prev <= '0;
      frame_ends    <= '0;
    end else if (vs_rise) begin
      line_cnt      <= LINE_CNT_W'(hs_rise);
      line_cnt_prev <= line_cnt;
      if (frame_ends != 2'd2) begin
        frame_ends <= frame_ends + 2'd1;
      end
    end else if (hs_rise && line_cnt != '1) begin
      line_cnt <= line_cnt + 1'b1;
    end
  end

  // ====================
  // mode flags
  // ====================

  // count before the first vsync is partial, so it is never trusted
  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vinfo_o <= '0;
    end else if (vs_rise) begin
      vinfo_o.vdata_detected <= (frame_ends != 2'd0);
      vinfo_o.palmode        <= (frame_ends != 2'd0) &&
                                (line_cnt >= LINE_CNT_W'(PAL_LINES_MIN));
      // interlaced frames alternate in length
      vinfo_o.n64_480i       <= (frame_ends == 2'd2) && (line_cnt != line_cnt_prev);
    end
  end

endmodule

//--- source/scanline_emu.sv
// Scanline emulation stage

`timescale 1ns/1ps

module scanline_emu #(
  parameter int COLOR_W = n64_ppu_pkg::COLOR_W
) (
  input  logic                 N64_CLK_i,
  input  logic                 arst_n_i,
  input  logic                 pix_valid_i,
  input  n64_ppu_pkg::pixel_t  pix_i,
  input  logic                 sl_en_i,
  input  n64_ppu_pkg::sl_str_t sl_str_i,
  output logic                 pix_valid_o,
  output n64_ppu_pkg::pixel_t  pix_o
);

  import n64_ppu_pkg::*;

  logic      vsync_q;
  logic      hsync_q;
  logic      vs_rise;
  logic      hs_rise;
  line_cnt_t line_cnt;
  line_cnt_t line_cur;
  logic      dim_en;

  // c - c*str/16, never below zero
  function automatic logic [COLOR_W-1:0] dim(input logic [COLOR_W-1:0] c,
                                             input sl_str_t            str);
    logic [COLOR_W+3:0] prod;
    prod = c * str;
    return c - prod[COLOR_W+3:4];
  endfunction

  assign vs_rise = pix_valid_i && pix_i.sync.vsync && !vsync_q;
  assign hs_rise = pix_valid_i && pix_i.sync.hsync && !hsync_q;

  // ====================
  // line position
  // ====================

  // index of the line the current pixel belongs to
  always_comb begin
    if (vs_rise) begin
      line_cur = '0;
    end else if (hs_rise) begin
      line_cur = line_cnt + 1'b1;
    end else begin
      line_cur = line_cnt;
    end
  end

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vsync_q  <= 1'b0;
      hsync_q  <= 1'b0;
      line_cnt <= '0;
    end else if (pix_valid_i) begin
      vsync_q  <= pix_i.sync.vsync;
      hsync_q  <= pix_i.sync.hsync;
      line_cnt <= line_cur;
    end
  end

  assign dim_en = sl_en_i && line_cur[0];

  // ====================
  // output register
  // ====================

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pix_valid_o <= 1'b0;
      pix_o       <= '0;
    end else begin
      pix_valid_o <= pix_valid_i;
      if (pix_valid_i) begin
        pix_o.sync  <= pix_i.sync;
        pix_o.rgb.r <= dim_en ? dim(pix_i.rgb.r, sl_str_i) : pix_i.rgb.r;
        pix_o.rgb.g <= dim_en ? dim(pix_i.rgb.g, sl_str_i) : pix_i.rgb.g;
        pix_o.rgb.b <= dim_en ? dim(pix_i.rgb.b, sl_str_i) : pix_i.rgb.b;
      end
    end
  end

  a_valid_delay: assert property (@(posedge N64_CLK_i) disable iff (!arst_n_i)
    pix_valid_o == $past(pix_valid_i));

endmodule
